// File: chip8_isa_pkg.sv
package chip8_isa_pkg;

   // field widths
   localparam int ADDR_W    = 12;
   localparam int BYTE_W    = 8;
   localparam int REG_IDX_W = 4;
   localparam int OP_W      = 16;
   localparam int DIGIT_W   = 4;

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [BYTE_W-1:0]    byte_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [OP_W-1:0]      opword_t;
   typedef logic [DIGIT_W-1:0]   digit_t;
   typedef logic [3*DIGIT_W-1:0] bcd_t;   // hundreds, tens, ones

   localparam addr_t PROG_START = 12'h200;   // programs load here

   localparam reg_idx_t FLAG_REG = 4'hF;    // VF

   // one shift per bit of a byte
   localparam int BCD_STAGES = BYTE_W;

endpackage

// File: chip8_ctrl_pkg.sv
package chip8_ctrl_pkg;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FETCH_HI,
      ST_FETCH_LO,
      ST_DECODE,
      ST_EXEC,
      ST_TRANSFER,   // FX55 / FX65
      ST_BCD_WAIT,
      ST_HALTED
   } core_state_t;

   // values match the low nibble of 8XYn
   typedef enum logic [3:0] {
      ALU_MOV  = 4'h0,
      ALU_OR   = 4'h1,
      ALU_AND  = 4'h2,
      ALU_XOR  = 4'h3,
      ALU_ADD  = 4'h4,
      ALU_SUB  = 4'h5,
      ALU_SHR  = 4'h6,
      ALU_SUBN = 4'h7,
      ALU_SHL  = 4'hE
   } alu_op_t;

endpackage

// File: chip8_mem.sv
`timescale 1ns/1ps

module chip8_mem
   import chip8_isa_pkg::*;
#(
   parameter int MEM_DEPTH = 4096
)
(
   input  logic  clk,
   input  logic  host_we,
   input  addr_t host_addr,
   input  byte_t host_wdata,
   output byte_t host_rdata,
   input  addr_t cpu_addr,
   input  logic  cpu_we,
   input  byte_t cpu_wdata,
   output byte_t cpu_rdata,
   input  logic  bcd_we,
   input  addr_t bcd_waddr,
   input  byte_t bcd_wdata,
   input  logic  run
);

   byte_t mem [MEM_DEPTH];

   logic  eng_we;
   addr_t eng_addr;
   byte_t eng_wdata;

   // digit writer wins the engine port
   assign eng_we    = bcd_we || cpu_we;
   assign eng_addr  = bcd_we ? bcd_waddr : cpu_addr;
   assign eng_wdata = bcd_we ? bcd_wdata : cpu_wdata;

   always_ff @(posedge clk)
   begin
      if (host_we)
         mem[host_addr] <= host_wdata;
      if (eng_we)
         mem[eng_addr] <= eng_wdata;
      host_rdata <= mem[host_addr];
      cpu_rdata  <= mem[eng_addr];   // core is waiting while digits go out
   end

   assert property (@(posedge clk) host_we |-> !run)
      else $error("host write while the engine runs");

   assert property (@(posedge clk) !(bcd_we && cpu_we))
      else $error("core and digit writer write in the same cycle");

endmodule

// File: chip8_regfile.sv
`timescale 1ns/1ps

module chip8_regfile
   import chip8_isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t rd_a_idx,
   input  reg_idx_t rd_b_idx,
   output byte_t    rd_a,
   output byte_t    rd_b,
   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  byte_t    wr_data,
   input  logic     flag_en,
   input  logic     flag_val
);

   byte_t v [16];

   assign rd_a = v[rd_a_idx];
   assign rd_b = v[rd_b_idx];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int k = 0; k < 16; k++)
         begin
            v[k] <= '0;
         end
      end
      else
      begin
         if (wr_en)
            v[wr_idx] <= wr_data;
         if (flag_en)
            v[FLAG_REG] <= {7'b0, flag_val};   // last, so VF result loses
      end
   end

endmodule

// File: chip8_alu.sv
`timescale 1ns/1ps

module chip8_alu
   import chip8_isa_pkg::*;
   import chip8_ctrl_pkg::*;
(
   input  alu_op_t op,
   input  byte_t   x,
   input  byte_t   y,
   output byte_t   result,
   output logic    flag,
   output logic    flag_en
);

   logic [8:0] sum;

   assign sum = {1'b0, x} + {1'b0, y};

   always_comb
   begin
      result  = x;
      flag    = 1'b0;
      flag_en = 1'b0;
      case (op)
         ALU_MOV: result = y;
         ALU_OR:  result = x | y;
         ALU_AND: result = x & y;
         ALU_XOR: result = x ^ y;
         ALU_ADD:
         begin
            result  = sum[7:0];
            flag    = sum[8];   // carry out
            flag_en = 1'b1;
         end
         ALU_SUB:
         begin
            result  = x - y;
            flag    = (x >= y);   // no borrow
            flag_en = 1'b1;
         end
         ALU_SHR:
         begin
            result  = x >> 1;
            flag    = x[0];
            flag_en = 1'b1;
         end
         ALU_SUBN:
         begin
            result  = y - x;
            flag    = (y >= x);
            flag_en = 1'b1;
         end
         ALU_SHL:
         begin
            result  = x << 1;
            flag    = x[7];
            flag_en = 1'b1;
         end
         default: result = x;
      endcase
   end

endmodule

// File: chip8_bcd_stage.sv
`timescale 1ns/1ps

module chip8_bcd_stage
   import chip8_isa_pkg::*;
#(
   parameter bit ACTIVE = 1'b1   // 0: pure delay stage
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  in_valid,
   input  addr_t in_addr,
   input  byte_t in_bin,
   input  bcd_t  in_bcd,
   output logic  out_valid,
   output addr_t out_addr,
   output byte_t out_bin,
   output bcd_t  out_bcd
);

   bcd_t adj;

   // add 3 to every digit of 5 or more
   always_comb
   begin
      adj = in_bcd;
      for (int d = 0; d < 3; d++)
      begin
         if (in_bcd[4*d +: 4] >= 4'd5)
            adj[4*d +: 4] = in_bcd[4*d +: 4] + 4'd3;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      out_addr <= in_addr;
      if (ACTIVE)
      begin
         out_bcd <= {adj[10:0], in_bin[7]};   // msb first
         out_bin <= {in_bin[6:0], 1'b0};
      end
      else
      begin
         out_bcd <= in_bcd;
         out_bin <= in_bin;
      end
   end

endmodule

// File: chip8_bcd_writer.sv
`timescale 1ns/1ps

module chip8_bcd_writer
   import chip8_isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  in_valid,
   input  addr_t in_addr,
   input  bcd_t  in_bcd,
   output logic  bcd_we,
   output addr_t bcd_waddr,
   output byte_t bcd_wdata,
   output logic  bcd_done
);

   logic [1:0] cnt;   // 0 hundreds, 1 tens, 2 ones
   logic       busy;
   logic       last;
   logic       free;
   addr_t      cur_addr;
   bcd_t       cur_bcd;
   logic       skid_valid;
   addr_t      skid_addr;
   bcd_t       skid_bcd;
   digit_t     digit;

   assign last      = busy && (cnt == 2'd2);
   assign free      = !busy || last;
   assign bcd_we    = busy;
   assign bcd_waddr = cur_addr + addr_t'(cnt);
   assign bcd_wdata = {4'b0, digit};
   assign bcd_done  = last;

   always_comb
   begin
      case (cnt)
         2'd0:    digit = cur_bcd[11:8];
         2'd1:    digit = cur_bcd[7:4];
         default: digit = cur_bcd[3:0];
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy       <= 1'b0;
         cnt        <= '0;
         skid_valid <= 1'b0;
      end
      else if (free)
      begin
         busy       <= skid_valid || in_valid;
         cnt        <= '0;
         skid_valid <= skid_valid && in_valid;   // skid drains, new one waits
      end
      else
      begin
         cnt        <= cnt + 2'd1;
         skid_valid <= skid_valid || in_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (free)
      begin
         cur_addr <= skid_valid ? skid_addr : in_addr;
         cur_bcd  <= skid_valid ? skid_bcd : in_bcd;
      end
      if (in_valid && (skid_valid || !free))
      begin
         skid_addr <= in_addr;
         skid_bcd  <= in_bcd;
      end
   end

   assert property (@(posedge clk) disable iff (rst) (in_valid && !free) |-> !skid_valid)
      else $error("second conversion waiting on a full skid entry");

endmodule

// File: chip8_core.sv
`timescale 1ns/1ps

module chip8_core
   import chip8_isa_pkg::*;
   import chip8_ctrl_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   output logic     halted,
   output addr_t    cpu_addr,
   input  byte_t    cpu_rdata,
   output logic     cpu_we,
   output byte_t    cpu_wdata,
   output reg_idx_t rd_a_idx,
   output reg_idx_t rd_b_idx,
   input  byte_t    rd_a,
   input  byte_t    rd_b,
   output logic     wr_en,
   output reg_idx_t wr_idx,
   output byte_t    wr_data,
   output alu_op_t  alu_op,
   input  byte_t    alu_result,
   input  logic     alu_flag,
   input  logic     alu_flag_en,
   output logic     flag_en,
   output logic     flag_val,
   output logic     bcd_valid,
   output byte_t    bcd_value,
   output addr_t    bcd_addr,
   input  logic     bcd_done
);

   core_state_t state;
   addr_t       pc;
   addr_t       i_reg;
   opword_t     op;
   reg_idx_t    xfer_idx;
   logic        xfer_phase;   // FX65 waits one cycle for read data
   reg_idx_t    x;
   reg_idx_t    y;
   byte_t       nn;
   addr_t       nnn;
   logic        is_load;
   logic        alu_code_ok;

   assign x           = op[11:8];
   assign y           = op[7:4];
   assign nn          = op[7:0];
   assign nnn         = op[11:0];
   assign is_load     = (nn == 8'h65);
   assign alu_code_ok = (op[3:0] <= 4'h7) || (op[3:0] == 4'hE);
   assign alu_op      = alu_op_t'(op[3:0]);
   assign halted      = (state == ST_HALTED);
   assign rd_a_idx    = (state == ST_TRANSFER) ? xfer_idx : x;
   assign rd_b_idx    = y;
   assign cpu_we      = (state == ST_TRANSFER) && !is_load;
   assign cpu_wdata   = rd_a;

   always_comb
   begin
      case (state)
         ST_FETCH_LO: cpu_addr = pc + 12'd1;
         ST_TRANSFER: cpu_addr = i_reg + addr_t'(xfer_idx);
         default:     cpu_addr = pc;
      endcase
   end

   always_comb
   begin
      wr_en    = 1'b0;
      wr_idx   = x;
      wr_data  = nn;
      flag_en  = 1'b0;
      flag_val = alu_flag;
      if (state == ST_EXEC)
      begin
         case (op[15:12])
            4'h6: wr_en = 1'b1;
            4'h7:
            begin
               wr_en   = 1'b1;
               wr_data = rd_a + nn;   // wraps, VF untouched
            end
            4'h8:
            begin
               wr_en   = alu_code_ok;
               wr_data = alu_result;
               flag_en = alu_code_ok && alu_flag_en;
            end
            default: wr_en = 1'b0;
         endcase
      end
      else if ((state == ST_TRANSFER) && is_load)
      begin
         wr_en   = xfer_phase;
         wr_idx  = xfer_idx;
         wr_data = cpu_rdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= ST_IDLE;
         pc         <= PROG_START;
         i_reg      <= '0;
         bcd_valid  <= 1'b0;
         xfer_idx   <= '0;
         xfer_phase <= 1'b0;
      end
      else
      begin
         bcd_valid <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               if (run)
                  state <= ST_FETCH_HI;
            end
            ST_FETCH_HI: state <= ST_FETCH_LO;
            ST_FETCH_LO: state <= ST_DECODE;
            ST_DECODE:
            begin
               pc    <= pc + 12'd2;
               state <= ST_EXEC;
            end
            ST_EXEC:
            begin
               state <= ST_FETCH_HI;
               case (op[15:12])
                  4'h1:
                  begin
                     if (nnn == pc - 12'd2)   // jump to itself
                        state <= ST_HALTED;
                     else
                        pc <= nnn;
                  end
                  4'h3:
                  begin
                     if (rd_a == nn)
                        pc <= pc + 12'd2;
                  end
                  4'h4:
                  begin
                     if (rd_a != nn)
                        pc <= pc + 12'd2;
                  end
                  4'h5:
                  begin
                     if (rd_a == rd_b)
                        pc <= pc + 12'd2;
                  end
                  4'hA: i_reg <= nnn;
                  4'hF:
                  begin
                     case (nn)
                        8'h1E: i_reg <= i_reg + addr_t'(rd_a);
                        8'h33:
                        begin
                           bcd_valid <= 1'b1;
                           state     <= ST_BCD_WAIT;
                        end
                        8'h55, 8'h65:
                        begin
                           xfer_idx   <= '0;
                           xfer_phase <= 1'b0;
                           state      <= ST_TRANSFER;
                        end
                        default: state <= ST_FETCH_HI;
                     endcase
                  end
                  default: state <= ST_FETCH_HI;   // 9XY0, BNNN and the rest
               endcase
            end
            ST_TRANSFER:
            begin
               if (is_load && !xfer_phase)
                  xfer_phase <= 1'b1;
               else
               begin
                  xfer_phase <= 1'b0;
                  if (xfer_idx == x)
                     state <= ST_FETCH_HI;
                  else
                     xfer_idx <= xfer_idx + 4'd1;
               end
            end
            ST_BCD_WAIT:
            begin
               if (bcd_done)
                  state <= ST_FETCH_HI;
            end
            default: state <= ST_HALTED;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_FETCH_LO)
         op[15:8] <= cpu_rdata;
      if (state == ST_DECODE)
         op[7:0] <= cpu_rdata;
      if (state == ST_EXEC)
      begin
         bcd_value <= rd_a;
         bcd_addr  <= i_reg;
      end
   end

   assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
      else $error("pc left an even address");

   assert property (@(posedge clk) disable iff (rst) state == ST_HALTED |=> state == ST_HALTED)
      else $error("core left the halted state without reset");

endmodule

// File: chip8_top.sv
`timescale 1ns/1ps

module chip8_top
   import chip8_isa_pkg::*;
   import chip8_ctrl_pkg::*;
#(
   parameter int MEM_DEPTH = 4096,
   parameter int STAGES    = BCD_STAGES
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  run,
   input  logic  host_we,
   input  addr_t host_addr,
   input  byte_t host_wdata,
   output byte_t host_rdata,
   output logic  halted
);

   addr_t    cpu_addr;
   byte_t    cpu_rdata;
   logic     cpu_we;
   byte_t    cpu_wdata;
   reg_idx_t rd_a_idx;
   reg_idx_t rd_b_idx;
   byte_t    rd_a;
   byte_t    rd_b;
   logic     wr_en;
   reg_idx_t wr_idx;
   byte_t    wr_data;
   logic     reg_flag_en;
   logic     reg_flag_val;
   alu_op_t  alu_op;
   byte_t    alu_result;
   logic     alu_flag;
   logic     alu_flag_en;
   logic     bcd_we;
   addr_t    bcd_waddr;
   byte_t    bcd_wdata;
   logic     bcd_done;

   // conversion pipeline, index 0 is the core side
   logic  st_valid [STAGES+1];
   addr_t st_addr  [STAGES+1];
   byte_t st_bin   [STAGES+1];
   bcd_t  st_bcd   [STAGES+1];

   assign st_bcd[0] = '0;

   chip8_mem #(.MEM_DEPTH(MEM_DEPTH)) chip8_mem_i (
      .clk(clk), .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
      .host_rdata(host_rdata), .cpu_addr(cpu_addr), .cpu_we(cpu_we),
      .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .bcd_we(bcd_we),
      .bcd_waddr(bcd_waddr), .bcd_wdata(bcd_wdata), .run(run)
   );

   chip8_regfile chip8_regfile_i (
      .clk(clk), .rst(rst), .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx), .rd_a(rd_a),
      .rd_b(rd_b), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
      .flag_en(reg_flag_en), .flag_val(reg_flag_val)
   );

   chip8_alu chip8_alu_i (
      .op(alu_op), .x(rd_a), .y(rd_b), .result(alu_result), .flag(alu_flag),
      .flag_en(alu_flag_en)
   );

   chip8_core chip8_core_i (
      .clk(clk), .rst(rst), .run(run), .halted(halted), .cpu_addr(cpu_addr),
      .cpu_rdata(cpu_rdata), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
      .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx), .rd_a(rd_a), .rd_b(rd_b),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .alu_op(alu_op),
      .alu_result(alu_result), .alu_flag(alu_flag), .alu_flag_en(alu_flag_en),
      .flag_en(reg_flag_en), .flag_val(reg_flag_val), .bcd_valid(st_valid[0]),
      .bcd_value(st_bin[0]), .bcd_addr(st_addr[0]), .bcd_done(bcd_done)
   );

   for (genvar i = 0; i < STAGES; i++)
   begin : g_bcd
      // first BCD_STAGES stages shift, any extra ones only delay
      chip8_bcd_stage #(.ACTIVE(i < BCD_STAGES)) chip8_bcd_stage_i (
         .clk(clk), .rst(rst), .in_valid(st_valid[i]), .in_addr(st_addr[i]),
         .in_bin(st_bin[i]), .in_bcd(st_bcd[i]), .out_valid(st_valid[i+1]),
         .out_addr(st_addr[i+1]), .out_bin(st_bin[i+1]), .out_bcd(st_bcd[i+1])
      );
   end

   chip8_bcd_writer chip8_bcd_writer_i (
      .clk(clk), .rst(rst), .in_valid(st_valid[STAGES]), .in_addr(st_addr[STAGES]),
      .in_bcd(st_bcd[STAGES]), .bcd_we(bcd_we), .bcd_waddr(bcd_waddr),
      .bcd_wdata(bcd_wdata), .bcd_done(bcd_done)
   );

endmodule

// File: chip8_checker.sv
`timescale 1ns/1ps

module chip8_checker
   import chip8_isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  check_en,
   input  addr_t host_addr,
   input  byte_t host_rdata,
   input  logic  halted,
   output int    byte_errors,
   output int    flag_errors
);

   localparam addr_t IMG_BASE = 12'h300;
   localparam int    IMG_SIZE = 512;

   byte_t exp_img [IMG_SIZE];   // model image of 0x300..0x4FF
   logic  rd_pend;
   addr_t rd_addr;
   logic  rst_d;
   logic  halted_d;
   int    byte_err_cnt = 0;
   int    flag_err_cnt = 0;

   assign byte_errors = byte_err_cnt;
   assign flag_errors = flag_err_cnt;

   task automatic set_expected(input int idx, input byte_t val);
      exp_img[idx] = val;
   endtask

   always @(posedge clk)
   begin
      rd_pend  <= check_en;
      rd_addr  <= host_addr;   // read data shows up one cycle later
      rst_d    <= rst;
      halted_d <= halted;
      if (rd_pend && (host_rdata !== exp_img[rd_addr - IMG_BASE]))
      begin
         $display("error host_rdata expected 0x%02h actual 0x%02h at address 0x%03h",
                  exp_img[rd_addr - IMG_BASE], host_rdata, rd_addr);
         byte_err_cnt = byte_err_cnt + 1;
      end
      if (rst_d && halted)
      begin
         $display("halted is high right after a reset");
         flag_err_cnt = flag_err_cnt + 1;
      end
      if (halted_d && !halted && !rst_d)
      begin
         $display("halted fell without a reset");
         flag_err_cnt = flag_err_cnt + 1;
      end
      if (check_en && !halted)
      begin
         $display("halted is low while the memory is read back");
         flag_err_cnt = flag_err_cnt + 1;
      end
   end

endmodule

// File: chip8_tb.sv
`timescale 1ns/1ps

module chip8_tb
   import chip8_isa_pkg::*;
();

   localparam int    N_PROGS     = 20;
   localparam int    N_RAND      = 40;
   localparam int    PROG_LEN    = 16 + 1 + N_RAND + 3;   // prefix, body, closing
   localparam int    CYCLE_LIMIT = N_PROGS * (N_RAND * 40 + 600);
   localparam addr_t IMG_BASE    = 12'h300;
   localparam int    IMG_SIZE    = 512;
   localparam addr_t I_MAX       = 12'h4F0;   // FF55 stays inside the image

   logic  clk;
   logic  rst;
   logic  run;
   logic  host_we;
   addr_t host_addr;
   byte_t host_wdata;
   byte_t host_rdata;
   logic  halted;
   logic  check_en;
   int    byte_errors;
   int    flag_errors;
   int    cycles = 0;

   integer  seed;
   byte_t   mem_m [4096];   // model memory
   byte_t   v_m [16];
   addr_t   i_m;
   opword_t prog [PROG_LEN];
   int      prog_cnt;
   logic    skip_m;         // next slot is jumped over

   chip8_top #(.MEM_DEPTH(4096), .STAGES(BCD_STAGES)) chip8_top_i (
      .clk(clk), .rst(rst), .run(run), .host_we(host_we), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_rdata(host_rdata), .halted(halted)
   );

   chip8_checker chip8_checker_i (
      .clk(clk), .rst(rst), .check_en(check_en), .host_addr(host_addr),
      .host_rdata(host_rdata), .halted(halted), .byte_errors(byte_errors),
      .flag_errors(flag_errors)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout, the programs did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fffffff) % n;
   endfunction

   function automatic byte_t fill_byte(input addr_t a);
      return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'hA5;
   endfunction

   task automatic exec_model(input opword_t op, input addr_t addr);
      reg_idx_t x;
      reg_idx_t y;
      byte_t    nn;
      byte_t    vx;
      byte_t    vy;
      byte_t    res;
      logic     fl;
      x      = op[11:8];
      y      = op[7:4];
      nn     = op[7:0];
      vx     = v_m[x];
      vy     = v_m[y];
      skip_m = 1'b0;
      case (op[15:12])
         4'h1: skip_m = (op[11:0] == addr + 12'd4);   // forward jumps span one slot
         4'h3: skip_m = (vx == nn);
         4'h4: skip_m = (vx != nn);
         4'h5: skip_m = (vx == vy);
         4'h6: v_m[x] = nn;
         4'h7: v_m[x] = vx + nn;   // VF untouched
         4'h8:
         begin
            case (op[3:0])
               4'h0:    res = vy;
               4'h1:    res = vx | vy;
               4'h2:    res = vx & vy;
               4'h3:    res = vx ^ vy;
               4'h4:    res = vx + vy;
               4'h5:    res = vx - vy;
               4'h6:    res = vx >> 1;
               4'h7:    res = vy - vx;
               default: res = vx << 1;
            endcase
            case (op[3:0])
               4'h4:    fl = (int'(vx) + int'(vy) > 255);
               4'h5:    fl = (vx >= vy);
               4'h6:    fl = vx[0];
               4'h7:    fl = (vy >= vx);
               default: fl = vx[7];
            endcase
            v_m[x] = res;
            if (op[3:0] >= 4'h4)
               v_m[15] = {7'b0, fl};   // flag wins over a VF result
         end
         4'hA: i_m = op[11:0];
         4'hF:
         begin
            case (nn)
               8'h1E: i_m = i_m + addr_t'(vx);
               8'h33:
               begin
                  mem_m[i_m]                = byte_t'(vx / 100);
                  mem_m[i_m + addr_t'(1)]   = byte_t'((vx / 10) % 10);
                  mem_m[i_m + addr_t'(2)]   = byte_t'(vx % 10);
               end
               8'h55:
               begin
                  for (int k = 0; k <= int'(x); k++)
                     mem_m[i_m + addr_t'(k)] = v_m[k];
               end
               8'h65:
               begin
                  for (int k = 0; k <= int'(x); k++)
                     v_m[k] = mem_m[i_m + addr_t'(k)];
               end
               default: ;
            endcase
         end
         default: ;   // 9XY0 and BNNN
      endcase
   endtask

   task automatic emit(input opword_t op);
      addr_t addr;
      addr = PROG_START + addr_t'(2 * prog_cnt);
      prog[prog_cnt] = op;
      prog_cnt++;
      if (skip_m)
         skip_m = 1'b0;
      else
         exec_model(op, addr);
   endtask

   function automatic opword_t random_op();
      reg_idx_t x;
      reg_idx_t y;
      byte_t    nn;
      addr_t    here;
      logic [3:0] code;
      opword_t  op;
      x    = reg_idx_t'(rand_below(16));
      y    = reg_idx_t'(rand_below(16));
      nn   = byte_t'(rand_below(256));
      here = PROG_START + addr_t'(2 * prog_cnt);
      code = 4'(rand_below(9));
      if (code == 4'd8)
         code = 4'hE;
      case (rand_below(14))
         0:       op = {4'h1, here + 12'd4};
         1:       op = {4'h3, x, (rand_below(2) != 0) ? v_m[x] : nn};   // hit half the time
         2:       op = {4'h4, x, (rand_below(2) != 0) ? v_m[x] : nn};
         3:       op = {4'h5, x, y, 4'h0};
         4:       op = {4'h6, x, nn};
         5:       op = {4'h7, x, nn};
         6, 7:    op = {4'h8, x, y, code};
         8:       op = {4'hA, IMG_BASE + addr_t'(rand_below(225))};
         9:
         begin
            if (i_m + addr_t'(v_m[x]) <= I_MAX)
               op = {4'hF, x, 8'h1E};
            else
               op = {4'hA, IMG_BASE + addr_t'(rand_below(225))};
         end
         10:      op = {4'hF, x, 8'h33};
         11:      op = {4'hF, x, 8'h55};
         12:      op = {4'hF, x, 8'h65};
         default: op = (rand_below(2) != 0) ? {4'h9, x, y, 4'h0} : {4'hB, x, nn};
      endcase
      return op;
   endfunction

   task automatic gen_program();
      prog_cnt = 0;
      skip_m   = 1'b0;
      i_m      = '0;
      for (int k = 0; k < 16; k++)
         v_m[k] = '0;
      for (int k = 0; k < 16; k++)
         emit({4'h6, reg_idx_t'(k), byte_t'(rand_below(256))});
      emit({4'hA, IMG_BASE + addr_t'(rand_below(225))});
      for (int k = 0; k < N_RAND; k++)
         emit(random_op());
      emit(16'hA380);
      emit(16'hFF55);
      emit({4'h1, PROG_START + addr_t'(2 * prog_cnt)});   // self-jump
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic write_byte(input addr_t a, input byte_t d);
      @(negedge clk);
      host_we    = 1'b1;
      host_addr  = a;
      host_wdata = d;
   endtask

   task automatic run_program();
      gen_program();
      for (int k = 0; k < IMG_SIZE; k++)
         chip8_checker_i.set_expected(k, mem_m[IMG_BASE + addr_t'(k)]);
      for (int k = 0; k < PROG_LEN; k++)
      begin
         write_byte(PROG_START + addr_t'(2 * k), prog[k][15:8]);
         write_byte(PROG_START + addr_t'(2 * k + 1), prog[k][7:0]);
      end
      @(negedge clk);
      host_we = 1'b0;
      run     = 1'b1;
      while (!halted)
         @(negedge clk);
      run = 1'b0;
      for (int k = 0; k < IMG_SIZE; k++)
      begin
         @(negedge clk);
         host_addr = IMG_BASE + addr_t'(k);
         check_en  = 1'b1;
      end
      @(negedge clk);
      check_en = 1'b0;
      @(negedge clk);
      apply_reset();
   endtask

   initial
   begin
      seed       = 32'h6f3e;
      rst        = 1'b1;
      run        = 1'b0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      check_en   = 1'b0;
      apply_reset();
      // background loaded once, later programs only overwrite code
      for (int a = 'h200; a < 'h500; a++)
      begin
         mem_m[a] = fill_byte(addr_t'(a));
         write_byte(addr_t'(a), mem_m[a]);
      end
      for (int p = 0; p < N_PROGS; p++)
         run_program();
      @(negedge clk);
      $display("errors: %0d readback, %0d halt flag", byte_errors, flag_errors);
      if (byte_errors == 0 && flag_errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: flist.f
chip8_isa_pkg.sv
chip8_ctrl_pkg.sv
chip8_mem.sv
chip8_regfile.sv
chip8_alu.sv
chip8_bcd_stage.sv
chip8_bcd_writer.sv
chip8_core.sv
chip8_top.sv
chip8_checker.sv
chip8_tb.sv

// File: Bender.yml
package:
  name: chip8_engine

sources:
  - files:
      - chip8_isa_pkg.sv
      - chip8_ctrl_pkg.sv
      - chip8_mem.sv
      - chip8_regfile.sv
      - chip8_alu.sv
      - chip8_bcd_stage.sv
      - chip8_bcd_writer.sv
      - chip8_core.sv
      - chip8_top.sv
  - target: test
    files:
      - chip8_checker.sv
      - chip8_tb.sv
